/* include/alu_tb_vectors.svh */
// directed alu vectors with the op, both operands and the expected result
`ifndef ALU_TB_VECTORS_SVH
`define ALU_TB_VECTORS_SVH

// each row holds op, operand a, operand b, expected data and expected overflow
typedef struct packed {
    logic [4:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] data;
    logic        ovf;
} vec_row_t;

localparam int NUM_VECS = 40;

localparam vec_row_t VECS [NUM_VECS] = '{
    '{ADD,    32'h00000005, 32'h00000007, 32'h0000000c, 1'b0},
    '{ADD,    32'h7fffffff, 32'h00000001, 32'h80000000, 1'b1},
    '{ADD,    32'hffffffff, 32'h00000001, 32'h00000000, 1'b0},
    '{SUB,    32'h0000000a, 32'h00000003, 32'h00000007, 1'b0},
    '{SUB,    32'h80000000, 32'h00000001, 32'h7fffffff, 1'b1},
    '{SUB,    32'h00000003, 32'h00000005, 32'hfffffffe, 1'b0},
    '{SLT,    32'hffffffff, 32'h00000001, 32'h00000001, 1'b0},
    '{SLT,    32'h00000001, 32'hffffffff, 32'h00000000, 1'b0},
    '{SLT,    32'h80000000, 32'h7fffffff, 32'h00000001, 1'b0},
    '{SEQ,    32'h12345678, 32'h12345678, 32'h00000001, 1'b0},
    '{SEQ,    32'h12345678, 32'h12345679, 32'h00000000, 1'b0},
    '{SRL,    32'h80000000, 32'h00000000, 32'h80000000, 1'b0},
    '{SRL,    32'h80000000, 32'h0000001f, 32'h00000001, 1'b0},
    '{SRL,    32'hffffffff, 32'h00000020, 32'h00000000, 1'b0},
    '{SRL,    32'hffffffff, 32'h00000100, 32'h00000000, 1'b0},
    // one row per float class, operand b unused
    '{FCLASS, 32'hff800000, 32'h0, 32'h1 << FCLASS_NEG_INF,    1'b0},
    '{FCLASS, 32'hbf800000, 32'h0, 32'h1 << FCLASS_NEG_NORMAL, 1'b0},
    '{FCLASS, 32'h80000001, 32'h0, 32'h1 << FCLASS_NEG_SUB,    1'b0},
    '{FCLASS, 32'h80000000, 32'h0, 32'h1 << FCLASS_NEG_ZERO,   1'b0},
    '{FCLASS, 32'h00000000, 32'h0, 32'h1 << FCLASS_POS_ZERO,   1'b0},
    '{FCLASS, 32'h00400000, 32'h0, 32'h1 << FCLASS_POS_SUB,    1'b0},
    '{FCLASS, 32'h3f800000, 32'h0, 32'h1 << FCLASS_POS_NORMAL, 1'b0},
    '{FCLASS, 32'h7f800000, 32'h0, 32'h1 << FCLASS_POS_INF,    1'b0},
    '{FCLASS, 32'h7f800001, 32'h0, 32'h1 << FCLASS_SNAN,       1'b0},
    '{FCLASS, 32'h7fc00000, 32'h0, 32'h1 << FCLASS_QNAN,       1'b0},
    // 1.0, -7.0, then the ties 2.5 and 3.5
    '{FCVTWS, 32'h3f800000, 32'h0, 32'h00000001, 1'b0},
    '{FCVTWS, 32'hc0e00000, 32'h0, 32'hfffffff9, 1'b0},
    '{FCVTWS, 32'h40200000, 32'h0, 32'h00000002, 1'b0},
    '{FCVTWS, 32'h40600000, 32'h0, 32'h00000004, 1'b0},
    '{FCVTWS, 32'h3f400000, 32'h0, 32'h00000001, 1'b0},
    '{FCVTWS, 32'hbf400000, 32'h0, 32'hffffffff, 1'b0},
    // 2^31 overflows, -2^31 just fits
    '{FCVTWS, 32'h4f000000, 32'h0, 32'h80000000, 1'b1},
    '{FCVTWS, 32'h7f800000, 32'h0, 32'h00000000, 1'b1},
    '{FCVTWS, 32'h7fc00000, 32'h0, 32'h00000000, 1'b1},
    '{FCVTWS, 32'hcf000000, 32'h0, 32'h80000000, 1'b0},
    '{FCVTWS, 32'h3e800000, 32'h0, 32'h00000000, 1'b0},
    '{FCVTWS, 32'h3f000000, 32'h0, 32'h00000000, 1'b0},
    // unused op codes
    '{5'd5,   32'h7fffffff, 32'h00000001, 32'h00000000, 1'b0},
    '{5'd6,   32'h7fffffff, 32'h00000001, 32'h00000000, 1'b0},
    '{5'd9,   32'h7fffffff, 32'h00000001, 32'h00000000, 1'b0}
};

`endif

/* dv/alu_tb.sv */
// testbench for the pipelined alu with directed vectors, random integer ops and in-order checks
`timescale 1ns/10ps

module alu_tb;

    import alu_pkg::*;

    `include "alu_tb_vectors.svh"

    localparam int NUM_RAND   = 40;
    localparam int LATENCY    = 3;
    localparam int MAX_CYCLES = NUM_VECS + NUM_RAND + LATENCY + 20;
    localparam int SEED       = 44956;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_valid;
    alu_op_e               i_op;
    logic [DATA_WIDTH-1:0] i_data_a;
    logic [DATA_WIDTH-1:0] i_data_b;
    logic                  o_valid;
    logic [DATA_WIDTH-1:0] o_data;
    logic                  o_overflow;

    // expected {overflow, data} and a label per issued operation
    logic [DATA_WIDTH:0] exp_q [$];
    string               name_q [$];
    int                  num_q [$];

    logic [2:0] valid_hist = '0;
    int         cycle = 0;
    int         issued = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         error_count = 0;
    alu_op_e    int_ops [5] = '{ADD, SUB, SLT, SRL, SEQ};

    alu_top uut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_op       (i_op),
        .i_data_a   (i_data_a),
        .i_data_b   (i_data_b),
        .o_valid    (o_valid),
        .o_data     (o_data),
        .o_overflow (o_overflow)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        // valid as the DUT samples it delayed by the pipeline depth
        if (!i_rst_n) begin
            valid_hist <= '0;
        end else begin
            valid_hist <= {valid_hist[1:0], i_valid};
        end
    end

    // integer result worked out from the ALU rules
    function automatic logic [DATA_WIDTH:0] expected_int_result(input alu_op_e op,
                                                                input logic [31:0] a,
                                                                input logic [31:0] b);
        longint wide;
        logic [DATA_WIDTH-1:0] addend;
        logic [DATA_WIDTH-1:0] data;
        logic ovf;
        data = '0;
        ovf  = 1'b0;
        wide = 0;
        // sub adds the two's complement of b
        addend = (op == SUB) ? -b : b;
        if (op == ADD || op == SUB) begin
            wide = longint'($signed(a)) + longint'($signed(addend));
        end
        case (op)
            ADD, SUB: begin
                data = wide[31:0];
                // overflow when the 64-bit signed sum leaves the 32-bit range
                ovf  = (wide > longint'(32'sh7fffffff)) || (wide < longint'(32'sh80000000));
            end
            SLT: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SEQ: data = (a == b) ? 32'd1 : 32'd0;
            SRL: data = (b >= 32'd32) ? 32'd0 : (a >> b[4:0]);
            default: data = '0;
        endcase
        return {ovf, data};
    endfunction

    task automatic issue_op(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                            input logic [DATA_WIDTH:0] expected);
        @(posedge i_clk);
        i_valid  <= 1'b1;
        i_op     <= op;
        i_data_a <= a;
        i_data_b <= b;
        issued++;
        exp_q.push_back(expected);
        num_q.push_back(issued);
        name_q.push_back($sformatf("op %0d a 0x%08h b 0x%08h", op, a, b));
    endtask

    // outputs are sampled on the falling edge while the registers are stable
    always @(negedge i_clk) begin
        logic [DATA_WIDTH:0] expected;
        string               name;
        int                  num;
        logic                ok;
        assert (o_valid === valid_hist[2]) else begin
            $display("Error: o_valid expected 0x%0h got 0x%0h at cycle %0d",
                     valid_hist[2], o_valid, cycle);
            error_count++;
        end
        if (o_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("A result came out at cycle %0d with no operation pending", cycle);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                num      = num_q.pop_front();
                ok       = 1'b1;
                assert (o_data === expected[DATA_WIDTH-1:0]) else begin
                    $display("Error: o_data expected 0x%08h got 0x%08h (test %0d)",
                             expected[DATA_WIDTH-1:0], o_data, num);
                    ok = 1'b0;
                end
                assert (o_overflow === expected[DATA_WIDTH]) else begin
                    $display("Error: o_overflow expected 0x%0h got 0x%0h (test %0d)",
                             expected[DATA_WIDTH], o_overflow, num);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_count++;
                end else begin
                    fail_count++;
                end
                $display("test %0d %s %s", num, name, ok ? "ok" : "wrong");
            end
        end
    end

    initial begin
        while (cycle < MAX_CYCLES) begin
            @(posedge i_clk);
        end
        $display("Timeout after %0d cycles with %0d results still missing",
                 MAX_CYCLES, exp_q.size());
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        i_clk    = 1'b0;
        i_rst_n  = 1'b0;
        i_valid  = 1'b0;
        i_op     = ADD;
        i_data_a = '0;
        i_data_b = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // directed rows at one per cycle
        for (int i = 0; i < NUM_VECS; i++) begin
            issue_op(alu_op_e'(VECS[i].op), VECS[i].a, VECS[i].b, {VECS[i].ovf, VECS[i].data});
        end

        // random integer ops issued back to back
        for (int i = 0; i < NUM_RAND; i++) begin
            op = int_ops[$urandom % 5];
            a  = $urandom;
            b  = $urandom;
            if (op == SRL) begin
                b = $urandom % 48;
            end else if (op == SEQ && ($urandom % 2) == 0) begin
                b = a;
            end
            issue_op(op, a, b, expected_int_result(op, a, b));
        end

        @(posedge i_clk);
        i_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge i_clk);
        end
        // o_valid must drop again once the pipeline drains
        repeat (2) @(negedge i_clk);

        $display("tests passed %0d failed %0d, other errors %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0 && pass_count == NUM_VECS + NUM_RAND) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* hdl/alu_decode.sv */
// alu stage 1: registers the op and operands, decodes op class and float fields
`timescale 1ns/10ps

module alu_decode (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  alu_pkg::alu_op_e                i_op,
    input  logic [alu_pkg::DATA_WIDTH-1:0]  i_data_a,
    input  logic [alu_pkg::DATA_WIDTH-1:0]  i_data_b,
    output logic                            o_valid,
    output alu_pkg::alu_op_e                o_op,
    output alu_pkg::op_class_e              o_class,
    output logic [alu_pkg::DATA_WIDTH-1:0]  o_data_a,
    output logic [alu_pkg::DATA_WIDTH-1:0]  o_data_b,
    output logic                            o_sign,
    output logic [alu_pkg::F_EXPO_W-1:0]    o_expo,
    output logic [alu_pkg::F_MANT_W-1:0]    o_mant
);

    import alu_pkg::*;

    op_class_e op_class;

    // map the op code onto the unit that produces its result
    always_comb begin
        case (i_op)
            ADD, SUB, SLT, SRL, SEQ: begin
                op_class = CLS_INT;
            end
            FCLASS, FCVTWS: begin
                op_class = CLS_FP;
            end
            default: begin
                op_class = CLS_NONE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // payload only loads on a valid issue
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_op     <= i_op;
            o_class  <= op_class;
            o_data_a <= i_data_a;
            o_data_b <= i_data_b;
            // split operand a as a single-precision float
            o_sign   <= i_data_a[DATA_WIDTH-1];
            o_expo   <= i_data_a[F_MANT_W +: F_EXPO_W];
            o_mant   <= i_data_a[F_MANT_W-1:0];
        end
    end

endmodule

/* hdl/alu_fp_exec.sv */
// alu stage 2 float datapath: fclass and fcvt.w.s with round to nearest even
`timescale 1ns/10ps

module alu_fp_exec (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  alu_pkg::alu_op_e                i_op,
    input  logic                            i_sign,
    input  logic [alu_pkg::F_EXPO_W-1:0]    i_expo,
    input  logic [alu_pkg::F_MANT_W-1:0]    i_mant,
    output logic [alu_pkg::DATA_WIDTH-1:0]  o_data,
    output logic                            o_overflow
);

    import alu_pkg::*;

    logic                  mant_zero;
    logic [DATA_WIDTH-1:0] fclass;
    logic [FCVT_W-1:0]     cvt_ext;
    logic [FCVT_W-1:0]     cvt_shifted;
    logic                  cvt_guard;
    logic                  cvt_round;
    logic                  cvt_sticky;
    logic                  cvt_up;
    logic [DATA_WIDTH-1:0] cvt_mag;
    logic [DATA_WIDTH-1:0] cvt_val;
    logic [DATA_WIDTH-1:0] fp_data;
    logic                  fp_ovf;

    assign mant_zero = (i_mant == '0);

    // one-hot class of operand a
    always_comb begin
        fclass = '0;
        if (i_expo == F_EXPO_MAX) begin
            if (mant_zero) begin
                fclass[i_sign ? FCLASS_NEG_INF : FCLASS_POS_INF] = 1'b1;
            end else if (i_mant[F_MANT_W-1]) begin
                fclass[FCLASS_QNAN] = 1'b1;
            end else begin
                fclass[FCLASS_SNAN] = 1'b1;
            end
        end else if (i_expo == '0) begin
            if (mant_zero) begin
                fclass[i_sign ? FCLASS_NEG_ZERO : FCLASS_POS_ZERO] = 1'b1;
            end else begin
                fclass[i_sign ? FCLASS_NEG_SUB : FCLASS_POS_SUB] = 1'b1;
            end
        end else begin
            fclass[i_sign ? FCLASS_NEG_NORMAL : FCLASS_POS_NORMAL] = 1'b1;
        end
    end

    // 1.m placed so that the binary point sits just above the mantissa
    assign cvt_ext     = {{(DATA_WIDTH-1){1'b0}}, 1'b1, i_mant};
    assign cvt_shifted = cvt_ext << (i_expo - F_BIAS);

    // guard is the integer lsb, round the first dropped bit, sticky the rest
    assign cvt_guard  = cvt_shifted[F_MANT_W];
    assign cvt_round  = cvt_shifted[F_MANT_W-1];
    assign cvt_sticky = |cvt_shifted[F_MANT_W-2:0];
    assign cvt_up     = cvt_round & (cvt_guard | cvt_sticky);

    assign cvt_mag = cvt_shifted[FCVT_W-1:F_MANT_W] + {{(DATA_WIDTH-1){1'b0}}, cvt_up};
    assign cvt_val = i_sign ? (~cvt_mag + 1'b1) : cvt_mag;

    always_comb begin
        fp_data = '0;
        fp_ovf  = 1'b0;
        case (i_op)
            FCLASS: begin
                fp_data = fclass;
            end
            FCVTWS: begin
                if (i_expo == F_EXPO_MAX) begin
                    // inf and nan cannot convert
                    fp_ovf = 1'b1;
                end else if (i_expo >= F_BIAS) begin
                    fp_data = cvt_val;
                    // -2^31 is the only value above the limit that still fits
                    fp_ovf = (i_expo > FCVT_MAX_EXPO) &&
                             !(i_sign && (cvt_val == {1'b1, {(DATA_WIDTH-1){1'b0}}}));
                end else if ((i_expo == F_BIAS - 1'b1) && !mant_zero) begin
                    // 0.5 < |x| < 1 rounds away to +-1
                    fp_data = i_sign ? '1 : {{(DATA_WIDTH-1){1'b0}}, 1'b1};
                end
            end
            default: begin
                fp_data = '0;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_data     <= '0;
            o_overflow <= 1'b0;
        end else if (i_valid) begin
            o_data     <= fp_data;
            o_overflow <= fp_ovf;
        end
    end

endmodule

/* hdl/alu_int_exec.sv */
// alu stage 2 integer datapath: add, sub, slt, seq and srl, registered
`timescale 1ns/10ps

module alu_int_exec (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  alu_pkg::alu_op_e                i_op,
    input  alu_pkg::op_class_e              i_class,
    input  logic [alu_pkg::DATA_WIDTH-1:0]  i_data_a,
    input  logic [alu_pkg::DATA_WIDTH-1:0]  i_data_b,
    output logic                            o_valid,
    output alu_pkg::op_class_e              o_class,
    output logic [alu_pkg::DATA_WIDTH-1:0]  o_data,
    output logic                            o_overflow
);

    import alu_pkg::*;

    logic [DATA_WIDTH-1:0] addend_b;
    logic [DATA_WIDTH-1:0] sum;
    logic                  sum_ovf;
    logic [DATA_WIDTH-1:0] int_data;
    logic                  int_ovf;

    // sub adds the two's complement of b
    assign addend_b = (i_op == SUB) ? (~i_data_b + 1'b1) : i_data_b;
    assign sum      = i_data_a + addend_b;

    // same-sign addends with a result of the other sign
    assign sum_ovf = (i_data_a[DATA_WIDTH-1] == addend_b[DATA_WIDTH-1]) &&
                     (sum[DATA_WIDTH-1] != i_data_a[DATA_WIDTH-1]);

    always_comb begin
        int_data = '0;
        int_ovf  = 1'b0;
        case (i_op)
            ADD, SUB: begin
                int_data = sum;
                int_ovf  = sum_ovf;
            end
            SLT: begin
                int_data = {{(DATA_WIDTH-1){1'b0}}, ($signed(i_data_a) < $signed(i_data_b))};
            end
            SEQ: begin
                int_data = {{(DATA_WIDTH-1){1'b0}}, (i_data_a == i_data_b)};
            end
            SRL: begin
                // shift by the whole of b, so 32 and up clears the result
                int_data = i_data_a >> i_data_b;
            end
            default: begin
                int_data = '0;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            o_class    <= CLS_NONE;
            o_data     <= '0;
            o_overflow <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_class    <= i_class;
                o_data     <= int_data;
                o_overflow <= int_ovf;
            end
        end
    end

endmodule

/* hdl/alu_pkg.sv */
// alu package with datapath widths, op codes, op classes and float constants
package alu_pkg;

    // operand and result width
    localparam int DATA_WIDTH = 32;

    // single-precision field widths
    localparam int F_EXPO_W = 8;
    localparam int F_MANT_W = 23;

    // width of the float-to-int shifter, integer part above the mantissa
    localparam int FCVT_W = DATA_WIDTH + F_MANT_W;

    // exponent bias and the all-ones exponent for inf and nan
    localparam logic [F_EXPO_W-1:0] F_BIAS     = 8'd127;
    localparam logic [F_EXPO_W-1:0] F_EXPO_MAX = 8'd255;

    // largest exponent that still fits a signed 32-bit result
    localparam logic [F_EXPO_W-1:0] FCVT_MAX_EXPO = 8'd157;

    // op codes, 5 and 6 are unused and fall to the default path
    typedef enum logic [4:0] {
        ADD    = 5'd0,
        SUB    = 5'd1,
        SLT    = 5'd2,
        SRL    = 5'd3,
        FCLASS = 5'd4,
        FCVTWS = 5'd7,
        SEQ    = 5'd8
    } alu_op_e;

    // which exec unit owns the result
    typedef enum logic [1:0] {
        CLS_NONE = 2'd0,
        CLS_INT  = 2'd1,
        CLS_FP   = 2'd2
    } op_class_e;

    // fclass result bit positions
    localparam int FCLASS_NEG_INF    = 0;
    localparam int FCLASS_NEG_NORMAL = 1;
    localparam int FCLASS_NEG_SUB    = 2;
    localparam int FCLASS_NEG_ZERO   = 3;
    localparam int FCLASS_POS_ZERO   = 4;
    localparam int FCLASS_POS_SUB    = 5;
    localparam int FCLASS_POS_NORMAL = 6;
    localparam int FCLASS_POS_INF    = 7;
    localparam int FCLASS_SNAN       = 8;
    localparam int FCLASS_QNAN       = 9;

endpackage

/* hdl/alu_top.sv */
// three-stage pipelined alu for integer and single-precision float ops
`timescale 1ns/10ps

module alu_top (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  alu_pkg::alu_op_e                i_op,
    input  logic [alu_pkg::DATA_WIDTH-1:0]  i_data_a,
    input  logic [alu_pkg::DATA_WIDTH-1:0]  i_data_b,
    output logic                            o_valid,
    output logic [alu_pkg::DATA_WIDTH-1:0]  o_data,
    output logic                            o_overflow
);

    import alu_pkg::*;

    // stage 1 outputs
    logic                  s1_valid;
    alu_op_e               s1_op;
    op_class_e             s1_class;
    logic [DATA_WIDTH-1:0] s1_a;
    logic [DATA_WIDTH-1:0] s1_b;
    logic                  s1_sign;
    logic [F_EXPO_W-1:0]   s1_expo;
    logic [F_MANT_W-1:0]   s1_mant;

    // stage 2 outputs, valid and class come from the int stage
    logic                  s2_valid;
    op_class_e             s2_class;
    logic [DATA_WIDTH-1:0] s2_int_data;
    logic                  s2_int_ovf;
    logic [DATA_WIDTH-1:0] s2_fp_data;
    logic                  s2_fp_ovf;

    alu_decode u_decode (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .o_valid  (s1_valid),
        .o_op     (s1_op),
        .o_class  (s1_class),
        .o_data_a (s1_a),
        .o_data_b (s1_b),
        .o_sign   (s1_sign),
        .o_expo   (s1_expo),
        .o_mant   (s1_mant)
    );

    alu_int_exec u_int_exec (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (s1_valid),
        .i_op       (s1_op),
        .i_class    (s1_class),
        .i_data_a   (s1_a),
        .i_data_b   (s1_b),
        .o_valid    (s2_valid),
        .o_class    (s2_class),
        .o_data     (s2_int_data),
        .o_overflow (s2_int_ovf)
    );

    alu_fp_exec u_fp_exec (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (s1_valid),
        .i_op       (s1_op),
        .i_sign     (s1_sign),
        .i_expo     (s1_expo),
        .i_mant     (s1_mant),
        .o_data     (s2_fp_data),
        .o_overflow (s2_fp_ovf)
    );

    alu_writeback u_writeback (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (s2_valid),
        .i_class    (s2_class),
        .i_int_data (s2_int_data),
        .i_int_ovf  (s2_int_ovf),
        .i_fp_data  (s2_fp_data),
        .i_fp_ovf   (s2_fp_ovf),
        .o_valid    (o_valid),
        .o_data     (o_data),
        .o_overflow (o_overflow)
    );

endmodule

/* hdl/alu_writeback.sv */
// alu stage 3: picks the int or float result by op class and drives the outputs
`timescale 1ns/10ps

module alu_writeback (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  alu_pkg::op_class_e              i_class,
    input  logic [alu_pkg::DATA_WIDTH-1:0]  i_int_data,
    input  logic                            i_int_ovf,
    input  logic [alu_pkg::DATA_WIDTH-1:0]  i_fp_data,
    input  logic                            i_fp_ovf,
    output logic                            o_valid,
    output logic [alu_pkg::DATA_WIDTH-1:0]  o_data,
    output logic                            o_overflow
);

    import alu_pkg::*;

    logic [DATA_WIDTH-1:0] sel_data;
    logic                  sel_ovf;

    always_comb begin
        case (i_class)
            CLS_INT: begin
                sel_data = i_int_data;
                sel_ovf  = i_int_ovf;
            end
            CLS_FP: begin
                sel_data = i_fp_data;
                sel_ovf  = i_fp_ovf;
            end
            default: begin
                sel_data = '0;
                sel_ovf  = 1'b0;
            end
        endcase
    end

    // outputs hold their last value between valid results
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            o_data     <= '0;
            o_overflow <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_data     <= sel_data;
                o_overflow <= sel_ovf;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the alu testbench with verilator, run it, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module alu_tb -o alu_sim > build.log 2>&1 \
    && ./obj_dir/alu_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete, see build.log and sim.log"

grep -qF '*** PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verilog.f */
+incdir+include
hdl/alu_pkg.sv
hdl/alu_decode.sv
hdl/alu_int_exec.sv
hdl/alu_fp_exec.sv
hdl/alu_writeback.sv
hdl/alu_top.sv
dv/alu_tb.sv
